/* run.sh */
#!/bin/sh
# Build and run the slice testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module dsp_slice_tb \
  -f src.f -o dsp_slice_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/dsp_slice_sim)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* src.f */
verilog/dsp_data_pkg.sv
verilog/dsp_ctrl_pkg.sv
verilog/frac_mult_18x18.sv
verilog/frac_mult_36x36.sv
verilog/lane_accum.sv
verilog/dsp_ctrl.sv
verilog/dsp_slice.sv
test/dsp_slice_tb.sv

/* test/dsp_slice_tb.sv */
`timescale 1ns/1ps

module dsp_slice_tb;

  // --------------------
  // DUT signals
  // --------------------
  localparam int max_rows = 64;   // Room for fixed and random rows

  logic                     clk;
  logic                     rst;
  logic                     in_valid;
  logic                     acc;
  logic                     clear;
  dsp_data_pkg::operand_t   a;
  dsp_data_pkg::operand_t   b;
  dsp_ctrl_pkg::mult_mode_t mode;
  logic                     out_valid;
  dsp_data_pkg::prod_t      result;

  // Stimulus table, one row per clock
  dsp_data_pkg::operand_t   row_a     [max_rows];
  dsp_data_pkg::operand_t   row_b     [max_rows];
  dsp_ctrl_pkg::mult_mode_t row_mode  [max_rows];
  logic                     row_acc   [max_rows];
  logic                     row_clear [max_rows];
  logic                     row_valid [max_rows];
  int                       n_rows = 0;

  // Reference model state
  logic                     model_full = 1'b0;                        // Running sum exists
  dsp_ctrl_pkg::mult_mode_t model_mode = dsp_ctrl_pkg::MODE_1X36;   // Lane layout of sum
  dsp_data_pkg::prod_t      model_sum  = '0;

  // Expected results and the falling edge each one is due on
  dsp_data_pkg::prod_t      exp_q[$];
  int                       due_q[$];
  int                       neg_cnt = 0;

  dsp_slice dsp_slice_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .acc       (acc),
    .clear     (clear),
    .a         (a),
    .b         (b),
    .mode      (mode),
    .out_valid (out_valid),
    .result    (result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  // --------------------
  // Reference model
  // --------------------
  // Lane k of the product is slice k of a times slice k of b, bit 0 first
  function automatic dsp_data_pkg::prod_t lane_product(input dsp_data_pkg::operand_t x,
                                                       input dsp_data_pkg::operand_t y,
                                                       input dsp_ctrl_pkg::mult_mode_t m);
    dsp_data_pkg::prod_t p;
    p = '0;
    case (m)
      dsp_ctrl_pkg::MODE_1X36: begin
        p = {{dsp_data_pkg::op_w{1'b0}}, x} * {{dsp_data_pkg::op_w{1'b0}}, y};
      end
      dsp_ctrl_pkg::MODE_2X18: begin
        for (int k = 0; k < 2; k++) begin
          p[k*36 +: 36] = {18'b0, x[k*18 +: 18]} * {18'b0, y[k*18 +: 18]};
        end
      end
      dsp_ctrl_pkg::MODE_4X9: begin
        for (int k = 0; k < 4; k++) begin
          p[k*18 +: 18] = {9'b0, x[k*9 +: 9]} * {9'b0, y[k*9 +: 9]};
        end
      end
      default: p = '0;   // Illegal code never driven
    endcase
    return p;
  endfunction

  // Each lane wraps modulo its own width
  function automatic dsp_data_pkg::prod_t lane_add(input dsp_data_pkg::prod_t x,
                                                   input dsp_data_pkg::prod_t y,
                                                   input dsp_ctrl_pkg::mult_mode_t m);
    dsp_data_pkg::prod_t s;
    s = '0;
    case (m)
      dsp_ctrl_pkg::MODE_1X36: s = x + y;
      dsp_ctrl_pkg::MODE_2X18: begin
        for (int k = 0; k < 2; k++) begin
          s[k*36 +: 36] = x[k*36 +: 36] + y[k*36 +: 36];
        end
      end
      dsp_ctrl_pkg::MODE_4X9: begin
        for (int k = 0; k < 4; k++) begin
          s[k*18 +: 18] = x[k*18 +: 18] + y[k*18 +: 18];
        end
      end
      default: s = '0;
    endcase
    return s;
  endfunction

  // Applies the load rule and queues the expected result
  task automatic predict_sample(input int i);
    logic                load_now;
    dsp_data_pkg::prod_t p;
    if (row_valid[i]) begin
      load_now = !row_acc[i] || row_clear[i] || !model_full || (row_mode[i] != model_mode);
      p = lane_product(row_a[i], row_b[i], row_mode[i]);
      model_sum  = load_now ? p : lane_add(model_sum, p, row_mode[i]);
      model_full = 1'b1;
      model_mode = row_mode[i];
      exp_q.push_back(model_sum);
      due_q.push_back(neg_cnt + 3);   // Strobe edge plus two stages
    end else if (row_clear[i]) begin
      model_full = 1'b0;              // Clear alone empties the sum
    end
  endtask

  // --------------------
  // Stimulus table
  // --------------------
  task automatic add_row(input dsp_data_pkg::operand_t ra, input dsp_data_pkg::operand_t rb,
                         input dsp_ctrl_pkg::mult_mode_t rm,
                         input logic racc, input logic rclr, input logic rv);
    row_a[n_rows]     = ra;
    row_b[n_rows]     = rb;
    row_mode[n_rows]  = rm;
    row_acc[n_rows]   = racc;
    row_clear[n_rows] = rclr;
    row_valid[n_rows] = rv;
    n_rows++;
  endtask

  function automatic dsp_data_pkg::operand_t random_operand();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[35:0];
  endfunction

  task automatic build_table();
    int unsigned              r;
    dsp_ctrl_pkg::mult_mode_t m;
    // Full product, corners first
    add_row('1, '1, dsp_ctrl_pkg::MODE_1X36, 1'b0, 1'b0, 1'b1);
    add_row('1, 36'h1, dsp_ctrl_pkg::MODE_1X36, 1'b0, 1'b0, 1'b1);
    add_row(36'h123456789, 36'hFEDCBA987, dsp_ctrl_pkg::MODE_1X36, 1'b0, 1'b0, 1'b1);
    add_row(random_operand(), random_operand(), dsp_ctrl_pkg::MODE_1X36, 1'b1, 1'b0, 1'b1);
    add_row('0, '0, dsp_ctrl_pkg::MODE_1X36, 1'b0, 1'b0, 1'b0);   // Idle gap
    add_row(random_operand(), random_operand(), dsp_ctrl_pkg::MODE_1X36, 1'b1, 1'b0, 1'b1);
    // Two lanes, mode change loads then large values wrap per lane
    add_row('1, '1, dsp_ctrl_pkg::MODE_2X18, 1'b1, 1'b0, 1'b1);
    add_row('1, '1, dsp_ctrl_pkg::MODE_2X18, 1'b1, 1'b0, 1'b1);
    add_row('1, '1, dsp_ctrl_pkg::MODE_2X18, 1'b1, 1'b0, 1'b1);
    add_row(random_operand(), random_operand(), dsp_ctrl_pkg::MODE_2X18, 1'b1, 1'b0, 1'b1);
    add_row('0, '0, dsp_ctrl_pkg::MODE_2X18, 1'b0, 1'b1, 1'b0);   // Clear alone
    add_row(random_operand(), random_operand(), dsp_ctrl_pkg::MODE_2X18, 1'b1, 1'b0, 1'b1);
    // Four lanes, only the last slice set shows lane order
    add_row(36'h0000001FF, '1, dsp_ctrl_pkg::MODE_4X9, 1'b1, 1'b0, 1'b1);
    add_row('1, '1, dsp_ctrl_pkg::MODE_4X9, 1'b1, 1'b0, 1'b1);
    add_row('1, '1, dsp_ctrl_pkg::MODE_4X9, 1'b1, 1'b0, 1'b1);
    add_row('1, '1, dsp_ctrl_pkg::MODE_4X9, 1'b1, 1'b0, 1'b1);
    add_row(random_operand(), random_operand(), dsp_ctrl_pkg::MODE_4X9, 1'b1, 1'b1, 1'b1);
    add_row(random_operand(), random_operand(), dsp_ctrl_pkg::MODE_4X9, 1'b1, 1'b0, 1'b1);
    add_row(random_operand(), random_operand(), dsp_ctrl_pkg::MODE_4X9, 1'b0, 1'b0, 1'b1);
    add_row('0, '0, dsp_ctrl_pkg::MODE_4X9, 1'b0, 1'b0, 1'b0);
    add_row('0, '0, dsp_ctrl_pkg::MODE_4X9, 1'b0, 1'b0, 1'b0);
    // Back to one lane, then a full wrap of the 72-bit sum
    add_row(random_operand(), random_operand(), dsp_ctrl_pkg::MODE_1X36, 1'b1, 1'b0, 1'b1);
    add_row('1, '1, dsp_ctrl_pkg::MODE_1X36, 1'b1, 1'b0, 1'b1);
    add_row('1, '1, dsp_ctrl_pkg::MODE_1X36, 1'b1, 1'b0, 1'b1);
    add_row(random_operand(), random_operand(), dsp_ctrl_pkg::MODE_1X36, 1'b1, 1'b0, 1'b0);
    // Random mix of modes, strobes and clears
    for (int k = 0; k < 14; k++) begin
      r = $urandom() % 3;
      if (r == 0) begin
        m = dsp_ctrl_pkg::MODE_1X36;
      end else if (r == 1) begin
        m = dsp_ctrl_pkg::MODE_2X18;
      end else begin
        m = dsp_ctrl_pkg::MODE_4X9;
      end
      add_row(random_operand(), random_operand(), m,
              ($urandom() % 4) != 0, ($urandom() % 8) == 0, ($urandom() % 5) != 0);
    end
  endtask

  task automatic drive_row(input int i);
    in_valid = row_valid[i];
    acc      = row_acc[i];
    clear    = row_clear[i];
    a        = row_a[i];
    b        = row_b[i];
    mode     = row_mode[i];
  endtask

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first failure");
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(81));
    rst      = 1'b1;
    in_valid = 1'b0;
    acc      = 1'b0;
    clear    = 1'b0;
    a        = '0;
    b        = '0;
    mode     = dsp_ctrl_pkg::MODE_1X36;
    build_table();
    repeat (2) @(posedge clk);   // Reset held two cycles
    #1;
    rst = 1'b0;
    assert (out_valid === 1'b0 && result === '0) else begin
      $display("error at %0t: after reset out_valid %b result %h, expected 0 and 0",
               $time, out_valid, result);
      abort_run();
    end
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      #1;
      drive_row(i);
      predict_sample(i);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    clear    = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (3) @(negedge clk);   // Idle tail must stay quiet
    $display("=== PASS ===");
    $finish;
  end

  // --------------------
  // Output checker
  // --------------------
  // Outputs settle after the rising edge, so look at the falling one
  always @(negedge clk) begin
    neg_cnt = neg_cnt + 1;
    if (out_valid === 1'b1) begin
      assert (exp_q.size() != 0) else begin
        $display("out_valid rose at %0t with no sample in flight", $time);
        abort_run();
      end
      assert (due_q[0] == neg_cnt) else begin
        $display("error at %0t: out_valid expected on cycle %0d, seen on cycle %0d",
                 $time, due_q[0], neg_cnt);
        abort_run();
      end
      assert (result === exp_q[0]) else begin
        $display("error at %0t: result expected %h, actual %h", $time, exp_q[0], result);
        abort_run();
      end
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end else if (exp_q.size() != 0) begin
      assert (due_q[0] > neg_cnt) else begin
        $display("error at %0t: out_valid expected on cycle %0d, actual low", $time, due_q[0]);
        abort_run();
      end
    end
  end

  // Watchdog sized from the table
  initial begin
    #1;
    #((n_rows + 10) * 100);
    $display("run timed out at %0t with %0d results still pending", $time, exp_q.size());
    abort_run();
  end

endmodule

/* verilog/dsp_ctrl.sv */
`timescale 1ns/1ps

// Slice control
// Tracks whether a running sum exists and in which mode
// Decides load versus add and delays strobes to match the datapath
module dsp_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  logic                     acc,
  input  logic                     clear,
  input  dsp_ctrl_pkg::mult_mode_t mode,
  output logic                     prod_valid,
  output logic                     load,
  output dsp_ctrl_pkg::mult_mode_t lane_mode,
  output logic                     out_valid
);

  dsp_ctrl_pkg::ctrl_state_t state;
  dsp_ctrl_pkg::ctrl_state_t state_d;
  dsp_ctrl_pkg::mult_mode_t  held_mode;   // Lane layout of the running sum
  logic                      load_d;      // Decided at the input cycle

  // --------------------
  // State machine
  // --------------------
  always_comb begin
    state_d = state;
    case (state)
      dsp_ctrl_pkg::ST_EMPTY: begin
        if (in_valid) begin
          state_d = dsp_ctrl_pkg::ST_ACCUM;   // First sample starts a sum
        end
      end
      dsp_ctrl_pkg::ST_ACCUM: begin
        // Clear together with a sample still leaves a fresh sum
        if (clear && !in_valid) begin
          state_d = dsp_ctrl_pkg::ST_EMPTY;
        end
      end
      default: state_d = dsp_ctrl_pkg::ST_EMPTY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= dsp_ctrl_pkg::ST_EMPTY;
      held_mode <= dsp_ctrl_pkg::MODE_1X36;
    end else begin
      state <= state_d;
      if (in_valid) begin
        held_mode <= mode;   // Every sample sets the lane layout
      end
    end
  end

  // --------------------
  // Load rule
  // --------------------
  // Any of these means the old sum is meaningless for this sample
  assign load_d = !acc
               || clear
               || (state == dsp_ctrl_pkg::ST_EMPTY)
               || (mode != held_mode);

  // --------------------
  // Strobe pipeline
  // --------------------
  // Product stage lines up with the multiplier register
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
      load       <= 1'b0;
      lane_mode  <= dsp_ctrl_pkg::MODE_1X36;
      out_valid  <= 1'b0;
    end else begin
      prod_valid <= in_valid;
      out_valid  <= prod_valid;   // Sum stage
      if (in_valid) begin
        load      <= load_d;
        lane_mode <= mode;
      end
    end
  end

  // --------------------
  // Checks
  // --------------------
  // Quad without split has no lane layout
  a_mode_legal: assert property (
    @(posedge clk) disable iff (rst)
    in_valid |-> (mode inside {dsp_ctrl_pkg::MODE_1X36,
                               dsp_ctrl_pkg::MODE_2X18,
                               dsp_ctrl_pkg::MODE_4X9})
  );

  // No result without a product one stage earlier
  a_out_after_prod: assert property (
    @(posedge clk) disable iff (rst)
    out_valid |-> $past(prod_valid)
  );

endmodule

/* verilog/dsp_ctrl_pkg.sv */
package dsp_ctrl_pkg;

  // --------------------
  // Mode encoding
  // --------------------
  // Bit positions inside a mode word
  localparam int split_bit = 0;   // Set for two or four lanes
  localparam int quad_bit  = 1;   // Set for four lanes only

  // Quad without split has no name and is illegal
  typedef enum logic [0:1] {
    MODE_1X36 = 2'b00,   // One 36x36 product
    MODE_2X18 = 2'b10,   // Two 18x18 products
    MODE_4X9  = 2'b11    // Four 9x9 products
  } mult_mode_t;

  // --------------------
  // Control state
  // --------------------
  // Whether the running sum holds anything worth adding to
  typedef enum logic {
    ST_EMPTY = 1'b0,     // No valid sum held
    ST_ACCUM = 1'b1      // Sum valid for the held mode
  } ctrl_state_t;

endpackage

/* verilog/dsp_data_pkg.sv */
package dsp_data_pkg;

  // --------------------
  // Datapath widths
  // --------------------
  // Fracture tree is fixed at 36 / 18 / 9
  localparam int op_w      = 36;              // Full operand
  localparam int half_w    = op_w / 2;        // 18x18 fracture half
  localparam int quarter_w = half_w / 2;      // Smallest multiplier
  localparam int prod_w    = 2 * op_w;        // Full product and running sum

  // Accumulator adder is cut into half_w wide segments
  localparam int seg_n     = prod_w / half_w;

  // --------------------
  // Vector types
  // --------------------
  // All ranges ascending so bit 0 is the MSB

  // One 36-bit operand
  typedef logic [0:op_w-1]     operand_t;

  // Operand half, also wide enough for one 9x9 product
  typedef logic [0:half_w-1]   half_t;

  // Product of one 18x18 block, or two 9x9 side by side
  typedef logic [0:2*half_w-1] half_prod_t;

  // Registered product and the lane-split sum
  typedef logic [0:prod_w-1]   prod_t;

endpackage

/* verilog/dsp_slice.sv */
`timescale 1ns/1ps

// Fracturable multiply-accumulate slice
// Sample at t gives out_valid and result at t+2
module dsp_slice (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  logic                     acc,
  input  logic                     clear,
  input  dsp_data_pkg::operand_t   a,
  input  dsp_data_pkg::operand_t   b,
  input  dsp_ctrl_pkg::mult_mode_t mode,
  output logic                     out_valid,
  output dsp_data_pkg::prod_t      result
);

  // --------------------
  // Product stage wires
  // --------------------
  logic                     prod_valid;   // Registered in_valid
  logic                     load;         // Take product alone
  dsp_ctrl_pkg::mult_mode_t lane_mode;    // Mode of the product in flight
  dsp_data_pkg::prod_t      prod;         // Registered multiplier output

  // Control path
  dsp_ctrl dsp_ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .acc        (acc),
    .clear      (clear),
    .mode       (mode),
    .prod_valid (prod_valid),
    .load       (load),
    .lane_mode  (lane_mode),
    .out_valid  (out_valid)
  );

  // Multiplier register enabled by the input strobe
  frac_mult_36x36 frac_mult_36x36_i (
    .clk  (clk),
    .rst  (rst),
    .en   (in_valid),
    .a    (a),
    .b    (b),
    .mode (mode),
    .prod (prod)
  );

  // Accumulator feeds the result directly
  lane_accum lane_accum_i (
    .clk        (clk),
    .rst        (rst),
    .prod_valid (prod_valid),
    .load       (load),
    .lane_mode  (lane_mode),
    .prod       (prod),
    .sum        (result)
  );

endmodule

/* verilog/frac_mult_18x18.sv */
`timescale 1ns/1ps

// 18x18 unsigned multiplier built from four 9x9 products
// With quad set it returns the two diagonal 9x9 products instead
module frac_mult_18x18 (
  input  dsp_data_pkg::half_t      a,
  input  dsp_data_pkg::half_t      b,
  input  logic                     quad,
  output dsp_data_pkg::half_prod_t prod
);

  // --------------------
  // Operand quarters
  // --------------------
  // Zero extended so each 9x9 product is formed at full 18 bits
  dsp_data_pkg::half_t a_hi;
  dsp_data_pkg::half_t a_lo;
  dsp_data_pkg::half_t b_hi;
  dsp_data_pkg::half_t b_lo;

  // Partial products
  dsp_data_pkg::half_t pp_ll;   // A low  * B low
  dsp_data_pkg::half_t pp_lh;   // A low  * B high
  dsp_data_pkg::half_t pp_hl;   // A high * B low
  dsp_data_pkg::half_t pp_hh;   // A high * B high

  // Middle column with its carry at bit 0
  logic [0:dsp_data_pkg::half_w] mid;
  dsp_data_pkg::half_t           top;      // Upper 18 bits of full product
  dsp_data_pkg::half_prod_t      full;     // Unsplit 36-bit product

  assign a_hi = dsp_data_pkg::half_t'(a[0:dsp_data_pkg::quarter_w-1]);
  assign a_lo = dsp_data_pkg::half_t'(a[dsp_data_pkg::quarter_w:dsp_data_pkg::half_w-1]);
  assign b_hi = dsp_data_pkg::half_t'(b[0:dsp_data_pkg::quarter_w-1]);
  assign b_lo = dsp_data_pkg::half_t'(b[dsp_data_pkg::quarter_w:dsp_data_pkg::half_w-1]);

  // --------------------
  // 9x9 products
  // --------------------
  assign pp_ll = a_lo * b_lo;
  assign pp_lh = a_lo * b_hi;
  assign pp_hl = a_hi * b_lo;
  assign pp_hh = a_hi * b_hi;

  // Cross terms plus the spill of the low product
  assign mid = {1'b0, pp_lh}
             + {1'b0, pp_hl}
             + {1'b0, dsp_data_pkg::half_t'(pp_ll[0:dsp_data_pkg::quarter_w-1])};

  // High product takes the upper 10 bits of the middle column
  assign top = pp_hh + dsp_data_pkg::half_t'(mid[0:dsp_data_pkg::quarter_w]);

  // Stitch the columns, lowest 9 bits come straight from pp_ll
  assign full = {top,
                 mid[dsp_data_pkg::quarter_w+1:dsp_data_pkg::half_w],
                 pp_ll[dsp_data_pkg::quarter_w:dsp_data_pkg::half_w-1]};

  // Quad mode drops the cross terms entirely
  assign prod = quad ? {pp_hh, pp_ll} : full;

endmodule

/* verilog/frac_mult_36x36.sv */
`timescale 1ns/1ps

// 36x36 unsigned multiplier from four fracturable 18x18 blocks
// Output is registered on en
module frac_mult_36x36 (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     en,
  input  dsp_data_pkg::operand_t   a,
  input  dsp_data_pkg::operand_t   b,
  input  dsp_ctrl_pkg::mult_mode_t mode,
  output dsp_data_pkg::prod_t      prod
);

  // Block outputs
  dsp_data_pkg::half_prod_t p_ll;   // A low  * B low
  dsp_data_pkg::half_prod_t p_lh;   // A low  * B high
  dsp_data_pkg::half_prod_t p_hl;   // A high * B low
  dsp_data_pkg::half_prod_t p_hh;   // A high * B high

  logic [0:dsp_data_pkg::op_w] mid;   // Middle column, carry at bit 0
  dsp_data_pkg::half_prod_t    top;   // Upper 36 bits of full product
  dsp_data_pkg::prod_t         full;
  dsp_data_pkg::prod_t         prod_d;

  // --------------------
  // 18x18 blocks
  // --------------------
  // Diagonals fracture further in quad mode
  frac_mult_18x18 mult_ll_i (
    .a    (a[dsp_data_pkg::half_w:dsp_data_pkg::op_w-1]),
    .b    (b[dsp_data_pkg::half_w:dsp_data_pkg::op_w-1]),
    .quad (mode[dsp_ctrl_pkg::quad_bit]),
    .prod (p_ll)
  );

  // Cross blocks never split
  frac_mult_18x18 mult_lh_i (
    .a    (a[dsp_data_pkg::half_w:dsp_data_pkg::op_w-1]),
    .b    (b[0:dsp_data_pkg::half_w-1]),
    .quad (1'b0),
    .prod (p_lh)
  );

  frac_mult_18x18 mult_hl_i (
    .a    (a[0:dsp_data_pkg::half_w-1]),
    .b    (b[dsp_data_pkg::half_w:dsp_data_pkg::op_w-1]),
    .quad (1'b0),
    .prod (p_hl)
  );

  frac_mult_18x18 mult_hh_i (
    .a    (a[0:dsp_data_pkg::half_w-1]),
    .b    (b[0:dsp_data_pkg::half_w-1]),
    .quad (mode[dsp_ctrl_pkg::quad_bit]),
    .prod (p_hh)
  );

  // --------------------
  // Column combine
  // --------------------
  assign mid = {1'b0, p_lh}
             + {1'b0, p_hl}
             + {1'b0, dsp_data_pkg::half_prod_t'(p_ll[0:dsp_data_pkg::half_w-1])};

  assign top  = p_hh + dsp_data_pkg::half_prod_t'(mid[0:dsp_data_pkg::half_w]);
  assign full = {top,
                 mid[dsp_data_pkg::half_w+1:dsp_data_pkg::op_w],
                 p_ll[dsp_data_pkg::half_w:dsp_data_pkg::op_w-1]};

  // Split modes take the diagonals side by side
  assign prod_d = mode[dsp_ctrl_pkg::split_bit] ? {p_hh, p_ll} : full;

  // Product register, holds between samples
  always_ff @(posedge clk) begin
    if (rst) begin
      prod <= '0;
    end else if (en) begin
      prod <= prod_d;
    end
  end

endmodule

/* verilog/lane_accum.sv */
`timescale 1ns/1ps

// 72-bit accumulator whose carry chain is cut at lane boundaries
// Segment 0 is the most significant, carries ripple toward it
module lane_accum (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     prod_valid,
  input  logic                     load,
  input  dsp_ctrl_pkg::mult_mode_t lane_mode,
  input  dsp_data_pkg::prod_t      prod,
  output dsp_data_pkg::prod_t      sum
);

  dsp_data_pkg::prod_t            addend;       // Held sum or zero on load
  dsp_data_pkg::prod_t            sum_d;
  logic [0:dsp_data_pkg::seg_n-1] carry_pass;   // Carry out of segment s may go on

  // --------------------
  // Lane joins
  // --------------------
  // Top segment carry always dropped
  // 36-bit boundary joins only in the full mode
  // 18-bit boundaries join unless four lanes
  assign carry_pass = {1'b0,
                       ~lane_mode[dsp_ctrl_pkg::quad_bit],
                       ~lane_mode[dsp_ctrl_pkg::split_bit],
                       ~lane_mode[dsp_ctrl_pkg::quad_bit]};

  // Load starts a new sum from this product
  assign addend = load ? '0 : sum;

  // --------------------
  // Segmented adder
  // --------------------
  always_comb begin
    logic [0:dsp_data_pkg::half_w] seg_res;   // Carry out at bit 0
    logic                          cy;
    cy    = 1'b0;
    sum_d = '0;
    // Walk from the least significant segment upward
    for (int s = dsp_data_pkg::seg_n - 1; s >= 0; s--) begin
      seg_res = {1'b0, addend[s*dsp_data_pkg::half_w +: dsp_data_pkg::half_w]}
              + {1'b0, prod[s*dsp_data_pkg::half_w +: dsp_data_pkg::half_w]}
              + {{dsp_data_pkg::half_w{1'b0}}, cy};
      sum_d[s*dsp_data_pkg::half_w +: dsp_data_pkg::half_w] = seg_res[1:dsp_data_pkg::half_w];
      cy = seg_res[0] & carry_pass[s];   // Lane boundary kills it
    end
  end

  // Sum register
  always_ff @(posedge clk) begin
    if (rst) begin
      sum <= '0;
    end else if (prod_valid) begin
      sum <= sum_d;
    end
  end

  // --------------------
  // Checks
  // --------------------
  // Result must stay put between samples since out_valid holds it
  a_sum_hold: assert property (
    @(posedge clk) disable iff (rst)
    !prod_valid |=> $stable(sum)
  );

endmodule
